// File: common/axi_defs.svh
`ifndef AXI_DEFS_SVH
`define AXI_DEFS_SVH

// byte address width of every request channel.
`define AXI_ADDR_WIDTH 32
// data bus width.
`define AXI_DATA_WIDTH 32
// one strobe bit per data byte.
`define AXI_STRB_WIDTH 4
// slave depth in words, valid byte addresses lie below MEM_WORDS*4.
`define MEM_WORDS 64

`endif

// File: common/axi_pkg.sv
`default_nettype none

`include "axi_defs.svh"

package axi_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        OKAY   = 2'b00,                           // normal access done.
        EXOKAY = 2'b01,                           // exclusive access done.
        SLVERR = 2'b10,                           // slave refused the access.
        DECERR = 2'b11                            // no slave at this address.
    } axi_response_t;

    typedef enum logic [1:0] {
        IDLE,                                     // waiting for a request.
        WRITE_RESP,                               // driving BVALID.
        READ_RESP                                 // driving RVALID.
    } slave_state_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // channel payloads, VALID and READY travel beside them
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [`AXI_ADDR_WIDTH-1:0] addr;         // write byte address.
    } axi_aw_t;

    typedef struct packed {
        logic [`AXI_DATA_WIDTH-1:0] data;         // write word.
        logic [`AXI_STRB_WIDTH-1:0] strb;         // byte enables.
    } axi_w_t;

    typedef struct packed {
        axi_response_t resp;                      // write status.
    } axi_b_t;

    typedef struct packed {
        logic [`AXI_ADDR_WIDTH-1:0] addr;         // read byte address.
    } axi_ar_t;

    typedef struct packed {
        logic [`AXI_DATA_WIDTH-1:0] data;         // read word.
        axi_response_t              resp;         // read status.
    } axi_r_t;

endpackage

`default_nettype wire

// File: axi_master/axi_master.sv
`timescale 1ns/1ns
`default_nettype none

`include "axi_defs.svh"

module axi_master (
    input  logic                       axi_ACLK,
    input  logic                       axi_ARESETN,
    input  logic                       router_write_cts_i,  // write path granted.
    input  logic                       router_read_cts_i,   // read path granted.
    input  logic                       write_start_i,
    input  logic [`AXI_ADDR_WIDTH-1:0] write_address_i,
    input  logic [`AXI_DATA_WIDTH-1:0] write_data_i,
    input  logic [`AXI_STRB_WIDTH-1:0] write_strobe_i,
    output logic                       write_done_o,
    output logic                       write_cts_o,
    output axi_pkg::axi_response_t     write_response_o,
    input  logic                       read_start_i,
    input  logic [`AXI_ADDR_WIDTH-1:0] read_address_i,
    output logic [`AXI_DATA_WIDTH-1:0] read_data_o,
    output logic                       read_done_o,
    output logic                       read_cts_o,
    output axi_pkg::axi_response_t     read_response_o,
    output axi_pkg::axi_aw_t           aw_o,
    output logic                       aw_valid_o,
    input  logic                       aw_ready_i,
    output axi_pkg::axi_w_t            w_o,
    output logic                       w_valid_o,
    input  logic                       w_ready_i,
    input  axi_pkg::axi_b_t            b_i,
    input  logic                       b_valid_i,
    output axi_pkg::axi_ar_t           ar_o,
    output logic                       ar_valid_o,
    input  logic                       ar_ready_i,
    input  axi_pkg::axi_r_t            r_i,
    input  logic                       r_valid_i
);

    logic aw_pend;                                // aw request still owed.
    logic w_pend;                                 // w request still owed.
    logic ar_pend;                                // ar request still owed.
    logic write_flush;
    logic read_flush;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign write_done_o = b_valid_i;              // responses are always taken.
    assign write_flush  = write_done_o & (b_i.resp == axi_pkg::SLVERR);

    always_ff @(posedge axi_ACLK) begin
        if (write_start_i & !write_flush) begin
            aw_o.addr <= write_address_i;         // payload held until transfer.
            w_o.data  <= write_data_i;
            w_o.strb  <= write_strobe_i;
        end
    end

    always_ff @(posedge axi_ACLK) begin : write_handshake
        if (!axi_ARESETN) begin
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
        end else if (write_flush) begin
            aw_pend <= 1'b0;                      // error kills pending work.
            w_pend  <= 1'b0;
        end else if (write_start_i) begin
            aw_pend <= 1'b1;
            w_pend  <= 1'b1;
        end else begin
            if (aw_valid_o & aw_ready_i) begin
                aw_pend <= 1'b0;                  // address taken.
            end
            if (w_valid_o & w_ready_i) begin
                w_pend <= 1'b0;                   // data taken.
            end
        end
    end : write_handshake

    // a switching router hides the request, which stays pending.
    assign aw_valid_o       = aw_pend & router_write_cts_i;
    assign w_valid_o        = w_pend & router_write_cts_i;
    assign write_response_o = b_i.resp;
    assign write_cts_o      = aw_ready_i & w_ready_i & router_write_cts_i;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign read_done_o = r_valid_i;
    assign read_flush  = read_done_o & (r_i.resp == axi_pkg::SLVERR);

    always_ff @(posedge axi_ACLK) begin
        if (read_start_i & !read_flush) begin
            ar_o.addr <= read_address_i;
        end
    end

    always_ff @(posedge axi_ACLK) begin : read_handshake
        if (!axi_ARESETN) begin
            ar_pend <= 1'b0;
        end else if (read_flush) begin
            ar_pend <= 1'b0;
        end else if (read_start_i) begin
            ar_pend <= 1'b1;
        end else if (ar_valid_o & ar_ready_i) begin
            ar_pend <= 1'b0;
        end
    end : read_handshake

    assign ar_valid_o      = ar_pend & router_read_cts_i;
    assign read_data_o     = r_i.data;
    assign read_response_o = r_i.resp;
    assign read_cts_o      = ar_ready_i & router_read_cts_i;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_write_flush : assert property (@(posedge axi_ACLK) disable iff (!axi_ARESETN)
        write_flush |=> !aw_valid_o & !w_valid_o);
    a_read_flush : assert property (@(posedge axi_ACLK) disable iff (!axi_ARESETN)
        read_flush |=> !ar_valid_o);
    // a response is taken in its first cycle, so it must not linger.
    a_b_pulse : assert property (@(posedge axi_ACLK) disable iff (!axi_ARESETN)
        b_valid_i |=> !b_valid_i);
    a_r_pulse : assert property (@(posedge axi_ACLK) disable iff (!axi_ARESETN)
        r_valid_i |=> !r_valid_i);

endmodule

`default_nettype wire

// File: verilog/axi_reg_slice.sv
`timescale 1ns/1ns
`default_nettype none

module axi_reg_slice (
    input  logic              axi_ACLK,
    input  logic              axi_ARESETN,
    input  axi_pkg::axi_aw_t  s_aw_i,
    input  logic              s_aw_valid_i,
    output logic              s_aw_ready_o,
    input  axi_pkg::axi_w_t   s_w_i,
    input  logic              s_w_valid_i,
    output logic              s_w_ready_o,
    input  axi_pkg::axi_ar_t  s_ar_i,
    input  logic              s_ar_valid_i,
    output logic              s_ar_ready_o,
    output axi_pkg::axi_aw_t  m_aw_o,
    output logic              m_aw_valid_o,
    input  logic              m_aw_ready_i,
    output axi_pkg::axi_w_t   m_w_o,
    output logic              m_w_valid_o,
    input  logic              m_w_ready_i,
    output axi_pkg::axi_ar_t  m_ar_o,
    output logic              m_ar_valid_o,
    input  logic              m_ar_ready_i,
    input  axi_pkg::axi_b_t   m_b_i,
    input  logic              m_b_valid_i,
    output axi_pkg::axi_b_t   s_b_o,
    output logic              s_b_valid_o,
    input  axi_pkg::axi_r_t   m_r_i,
    input  logic              m_r_valid_i,
    output axi_pkg::axi_r_t   s_r_o,
    output logic              s_r_valid_o
);

    logic aw_full;                                // aw stage holds a request.
    logic w_full;
    logic ar_full;

    // a stage takes a new entry when empty or emptying this cycle.
    assign s_aw_ready_o = !aw_full | m_aw_ready_i;
    assign s_w_ready_o  = !w_full | m_w_ready_i;
    assign s_ar_ready_o = !ar_full | m_ar_ready_i;

    always_ff @(posedge axi_ACLK) begin : stage_flags
        if (!axi_ARESETN) begin
            aw_full <= 1'b0;
            w_full  <= 1'b0;
            ar_full <= 1'b0;
        end else begin
            aw_full <= (s_aw_valid_i & s_aw_ready_o) | (aw_full & !m_aw_ready_i);
            w_full  <= (s_w_valid_i & s_w_ready_o) | (w_full & !m_w_ready_i);
            ar_full <= (s_ar_valid_i & s_ar_ready_o) | (ar_full & !m_ar_ready_i);
        end
    end : stage_flags

    always_ff @(posedge axi_ACLK) begin : stage_data
        if (s_aw_valid_i & s_aw_ready_o) begin
            m_aw_o <= s_aw_i;
        end
        if (s_w_valid_i & s_w_ready_o) begin
            m_w_o <= s_w_i;
        end
        if (s_ar_valid_i & s_ar_ready_o) begin
            m_ar_o <= s_ar_i;
        end
    end : stage_data

    assign m_aw_valid_o = aw_full;
    assign m_w_valid_o  = w_full;
    assign m_ar_valid_o = ar_full;

    assign s_b_o       = m_b_i;                   // responses go straight back.
    assign s_b_valid_o = m_b_valid_i;
    assign s_r_o       = m_r_i;
    assign s_r_valid_o = m_r_valid_i;

    a_aw_stable : assert property (@(posedge axi_ACLK) disable iff (!axi_ARESETN)
        (m_aw_valid_o & !m_aw_ready_i) |=> m_aw_valid_o & $stable(m_aw_o));
    a_w_stable : assert property (@(posedge axi_ACLK) disable iff (!axi_ARESETN)
        (m_w_valid_o & !m_w_ready_i) |=> m_w_valid_o & $stable(m_w_o));
    a_ar_stable : assert property (@(posedge axi_ACLK) disable iff (!axi_ARESETN)
        (m_ar_valid_o & !m_ar_ready_i) |=> m_ar_valid_o & $stable(m_ar_o));

endmodule

`default_nettype wire

// File: axi_slave/axi_mem_slave.sv
`timescale 1ns/1ns
`default_nettype none

`include "axi_defs.svh"

module axi_mem_slave (
    input  logic              axi_ACLK,
    input  logic              axi_ARESETN,
    input  axi_pkg::axi_aw_t  aw_i,
    input  logic              aw_valid_i,
    output logic              aw_ready_o,
    input  axi_pkg::axi_w_t   w_i,
    input  logic              w_valid_i,
    output logic              w_ready_o,
    output axi_pkg::axi_b_t   b_o,
    output logic              b_valid_o,
    input  axi_pkg::axi_ar_t  ar_i,
    input  logic              ar_valid_i,
    output logic              ar_ready_o,
    output axi_pkg::axi_r_t   r_o,
    output logic              r_valid_o
);

    localparam int IDX_W = $clog2(`MEM_WORDS);   // word index width.

    axi_pkg::slave_state_t        state;
    logic [`AXI_DATA_WIDTH-1:0]   mem [`MEM_WORDS];
    logic                         write_take;    // aw and w accepted together.
    logic                         read_take;
    logic                         aw_in_range;
    logic                         ar_in_range;
    logic [IDX_W-1:0]             aw_idx;
    logic [IDX_W-1:0]             ar_idx;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // acceptance, write wins over read
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign write_take = (state == axi_pkg::IDLE) & aw_valid_i & w_valid_i;
    assign read_take  = (state == axi_pkg::IDLE) & ar_valid_i & !(aw_valid_i & w_valid_i);

    assign aw_ready_o = write_take;               // address and data go as a pair.
    assign w_ready_o  = write_take;
    assign ar_ready_o = read_take;

    assign aw_in_range = aw_i.addr < (`MEM_WORDS * 4);
    assign ar_in_range = ar_i.addr < (`MEM_WORDS * 4);
    assign aw_idx      = aw_i.addr[IDX_W+1:2];
    assign ar_idx      = ar_i.addr[IDX_W+1:2];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state and memory
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge axi_ACLK) begin : fsm
        if (!axi_ARESETN) begin
            state <= axi_pkg::IDLE;
            for (int i = 0; i < `MEM_WORDS; i++) begin
                mem[i] <= '0;                     // memory starts blank.
            end
        end else begin
            case (state)
                axi_pkg::IDLE: begin
                    if (write_take) begin
                        if (aw_in_range) begin
                            for (int b = 0; b < `AXI_STRB_WIDTH; b++) begin
                                if (w_i.strb[b]) begin
                                    mem[aw_idx][8*b +: 8] <= w_i.data[8*b +: 8];
                                end
                            end
                        end
                        state <= axi_pkg::WRITE_RESP;
                    end else if (read_take) begin
                        state <= axi_pkg::READ_RESP;
                    end
                end
                default: begin
                    state <= axi_pkg::IDLE;       // bready/rready are tied high.
                end
            endcase
        end
    end : fsm

    always_ff @(posedge axi_ACLK) begin : resp_payload
        if (write_take) begin
            b_o.resp <= aw_in_range ? axi_pkg::OKAY : axi_pkg::SLVERR;
        end
        if (read_take) begin
            r_o.data <= ar_in_range ? mem[ar_idx] : '0;   // bad address reads zero.
            r_o.resp <= ar_in_range ? axi_pkg::OKAY : axi_pkg::SLVERR;
        end
    end : resp_payload

    assign b_valid_o = (state == axi_pkg::WRITE_RESP);
    assign r_valid_o = (state == axi_pkg::READ_RESP);

    a_ready_idle : assert property (@(posedge axi_ACLK) disable iff (!axi_ARESETN)
        (state != axi_pkg::IDLE) |-> !aw_ready_o & !ar_ready_o);

endmodule

`default_nettype wire

// File: verilog/axi_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

`include "axi_defs.svh"

module axi_subsystem (
    input  logic                       axi_ACLK,
    input  logic                       axi_ARESETN,
    input  logic                       write_grant_i,    // router write path open.
    input  logic                       read_grant_i,     // router read path open.
    input  logic                       write_start_i,
    input  logic [`AXI_ADDR_WIDTH-1:0] write_address_i,
    input  logic [`AXI_DATA_WIDTH-1:0] write_data_i,
    input  logic [`AXI_STRB_WIDTH-1:0] write_strobe_i,
    output logic                       write_done_o,
    output logic                       write_cts_o,
    output axi_pkg::axi_response_t     write_response_o,
    input  logic                       read_start_i,
    input  logic [`AXI_ADDR_WIDTH-1:0] read_address_i,
    output logic [`AXI_DATA_WIDTH-1:0] read_data_o,
    output logic                       read_done_o,
    output logic                       read_cts_o,
    output axi_pkg::axi_response_t     read_response_o
);

    // master side of the slice.
    axi_pkg::axi_aw_t mst_aw;
    axi_pkg::axi_w_t  mst_w;
    axi_pkg::axi_ar_t mst_ar;
    axi_pkg::axi_b_t  mst_b;
    axi_pkg::axi_r_t  mst_r;
    logic mst_aw_valid, mst_aw_ready, mst_w_valid, mst_w_ready;
    logic mst_ar_valid, mst_ar_ready, mst_b_valid, mst_r_valid;

    // slave side of the slice.
    axi_pkg::axi_aw_t slv_aw;
    axi_pkg::axi_w_t  slv_w;
    axi_pkg::axi_ar_t slv_ar;
    axi_pkg::axi_b_t  slv_b;
    axi_pkg::axi_r_t  slv_r;
    logic slv_aw_valid, slv_aw_ready, slv_w_valid, slv_w_ready;
    logic slv_ar_valid, slv_ar_ready, slv_b_valid, slv_r_valid;

    axi_master u_master (
        .axi_ACLK           (axi_ACLK),
        .axi_ARESETN        (axi_ARESETN),
        .router_write_cts_i (write_grant_i),
        .router_read_cts_i  (read_grant_i),
        .write_start_i      (write_start_i),
        .write_address_i    (write_address_i),
        .write_data_i       (write_data_i),
        .write_strobe_i     (write_strobe_i),
        .write_done_o       (write_done_o),
        .write_cts_o        (write_cts_o),
        .write_response_o   (write_response_o),
        .read_start_i       (read_start_i),
        .read_address_i     (read_address_i),
        .read_data_o        (read_data_o),
        .read_done_o        (read_done_o),
        .read_cts_o         (read_cts_o),
        .read_response_o    (read_response_o),
        .aw_o               (mst_aw),
        .aw_valid_o         (mst_aw_valid),
        .aw_ready_i         (mst_aw_ready),
        .w_o                (mst_w),
        .w_valid_o          (mst_w_valid),
        .w_ready_i          (mst_w_ready),
        .b_i                (mst_b),
        .b_valid_i          (mst_b_valid),
        .ar_o               (mst_ar),
        .ar_valid_o         (mst_ar_valid),
        .ar_ready_i         (mst_ar_ready),
        .r_i                (mst_r),
        .r_valid_i          (mst_r_valid)
    );

    axi_reg_slice u_slice (
        .axi_ACLK     (axi_ACLK),
        .axi_ARESETN  (axi_ARESETN),
        .s_aw_i       (mst_aw),
        .s_aw_valid_i (mst_aw_valid),
        .s_aw_ready_o (mst_aw_ready),
        .s_w_i        (mst_w),
        .s_w_valid_i  (mst_w_valid),
        .s_w_ready_o  (mst_w_ready),
        .s_ar_i       (mst_ar),
        .s_ar_valid_i (mst_ar_valid),
        .s_ar_ready_o (mst_ar_ready),
        .m_aw_o       (slv_aw),
        .m_aw_valid_o (slv_aw_valid),
        .m_aw_ready_i (slv_aw_ready),
        .m_w_o        (slv_w),
        .m_w_valid_o  (slv_w_valid),
        .m_w_ready_i  (slv_w_ready),
        .m_ar_o       (slv_ar),
        .m_ar_valid_o (slv_ar_valid),
        .m_ar_ready_i (slv_ar_ready),
        .m_b_i        (slv_b),
        .m_b_valid_i  (slv_b_valid),
        .s_b_o        (mst_b),
        .s_b_valid_o  (mst_b_valid),
        .m_r_i        (slv_r),
        .m_r_valid_i  (slv_r_valid),
        .s_r_o        (mst_r),
        .s_r_valid_o  (mst_r_valid)
    );

    axi_mem_slave u_slave (
        .axi_ACLK    (axi_ACLK),
        .axi_ARESETN (axi_ARESETN),
        .aw_i        (slv_aw),
        .aw_valid_i  (slv_aw_valid),
        .aw_ready_o  (slv_aw_ready),
        .w_i         (slv_w),
        .w_valid_i   (slv_w_valid),
        .w_ready_o   (slv_w_ready),
        .b_o         (slv_b),
        .b_valid_o   (slv_b_valid),
        .ar_i        (slv_ar),
        .ar_valid_i  (slv_ar_valid),
        .ar_ready_o  (slv_ar_ready),
        .r_o         (slv_r),
        .r_valid_o   (slv_r_valid)
    );

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,             // clock period.
    parameter int RESET_CYCLES = 3               // rising edges with reset low.
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin : clock_wave
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end : clock_wave

    initial begin : reset_wave
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;                         // released on a rising edge.
    end : reset_wave

endmodule

`default_nettype wire

// File: verification/tb_axi_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

`include "axi_defs.svh"

module tb_axi_subsystem;

    localparam int IDX_W          = $clog2(`MEM_WORDS);
    localparam int PAIR_OPS       = 16;          // tests 2 and 3 each issue 8 pairs.
    localparam int STALL_OPS      = 40;
    localparam int RANDOM_OPS     = 200;
    localparam int TOTAL_OPS      = 2 * PAIR_OPS + 2 + `MEM_WORDS + STALL_OPS + RANDOM_OPS;
    localparam int CYCLES_PER_OP  = 40;          // cts wait, two stalls and the handshake.
    localparam int TIMEOUT_CYCLES = TOTAL_OPS * CYCLES_PER_OP + 1000;

    logic                       axi_ACLK;
    logic                       axi_ARESETN;
    logic                       write_grant;
    logic                       read_grant;
    logic                       write_start;
    logic [`AXI_ADDR_WIDTH-1:0] write_address;
    logic [`AXI_DATA_WIDTH-1:0] write_data;
    logic [`AXI_STRB_WIDTH-1:0] write_strobe;
    logic                       write_done;
    logic                       write_cts;
    axi_pkg::axi_response_t     write_response;
    logic                       read_start;
    logic [`AXI_ADDR_WIDTH-1:0] read_address;
    logic [`AXI_DATA_WIDTH-1:0] read_data;
    logic                       read_done;
    logic                       read_cts;
    axi_pkg::axi_response_t     read_response;

    logic [`AXI_DATA_WIDTH-1:0] ref_mem [`MEM_WORDS];   // expected slave contents.
    integer      seed;                           // stimulus stream.
    integer      grant_seed;                     // stall stream.
    logic        stall_en;
    int          stall_cnt;
    logic [31:0] grant_rnd;
    int          test_errs;
    int          pass_cnt;
    int          fail_cnt;
    int          writes_issued;
    int          reads_issued;
    int          write_done_cnt;
    int          read_done_cnt;
    int          cycle_cnt;

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(3)) u_clock_gen (
        .clk_o   (axi_ACLK),
        .rst_n_o (axi_ARESETN)
    );

    axi_subsystem u_axi_subsystem (
        .axi_ACLK         (axi_ACLK),
        .axi_ARESETN      (axi_ARESETN),
        .write_grant_i    (write_grant),
        .read_grant_i     (read_grant),
        .write_start_i    (write_start),
        .write_address_i  (write_address),
        .write_data_i     (write_data),
        .write_strobe_i   (write_strobe),
        .write_done_o     (write_done),
        .write_cts_o      (write_cts),
        .write_response_o (write_response),
        .read_start_i     (read_start),
        .read_address_i   (read_address),
        .read_data_o      (read_data),
        .read_done_o      (read_done),
        .read_cts_o       (read_cts),
        .read_response_o  (read_response)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_data(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_resp(input string name, input axi_pkg::axi_response_t got,
                              input axi_pkg::axi_response_t exp);
        assert (got === exp) else begin
            $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_count(input string kind, input int seen, input int issued);
        assert (seen == issued) else begin
            $display("%0d %s done pulses seen for %0d issued", seen, kind, issued);
            test_errs++;
        end
    endtask

    // strobed bytes take the new value, the rest keep the old word.
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    function automatic logic [31:0] random_address(input logic out_of_range);
        logic [31:0] r;
        r = $random(seed);
        if (out_of_range) begin
            return `MEM_WORDS * 4 + {4'b0, r[27:2], 2'b00};   // anywhere past the top.
        end else begin
            return {{(30 - IDX_W){1'b0}}, r[IDX_W-1:0], 2'b00};
        end
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // transactions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic issue_write(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        logic [IDX_W-1:0]       idx;
        axi_pkg::axi_response_t exp_resp;
        @(negedge axi_ACLK);
        check_bit("write_cts_o", write_cts, write_grant);   // empty slice, grant decides.
        while (!write_cts) begin
            @(negedge axi_ACLK);                 // wait for a clear path.
            check_bit("write_cts_o", write_cts, write_grant);
        end
        @(posedge axi_ACLK);
        write_start   <= 1'b1;
        write_address <= addr;
        write_data    <= data;
        write_strobe  <= strb;
        @(posedge axi_ACLK);
        write_start   <= 1'b0;                   // one-cycle strobe.
        @(negedge axi_ACLK);
        while (!write_done) @(negedge axi_ACLK);
        exp_resp = axi_pkg::SLVERR;
        if (addr < `MEM_WORDS * 4) begin
            idx          = addr[IDX_W+1:2];
            ref_mem[idx] = merge_bytes(ref_mem[idx], data, strb);
            exp_resp     = axi_pkg::OKAY;
        end
        check_resp("write_response_o", write_response, exp_resp);
        writes_issued++;
    endtask

    task automatic issue_read(input logic [31:0] addr);
        logic [IDX_W-1:0]           idx;
        logic [`AXI_DATA_WIDTH-1:0] exp_data;
        axi_pkg::axi_response_t     exp_resp;
        @(negedge axi_ACLK);
        check_bit("read_cts_o", read_cts, read_grant);
        while (!read_cts) begin
            @(negedge axi_ACLK);
            check_bit("read_cts_o", read_cts, read_grant);
        end
        @(posedge axi_ACLK);
        read_start   <= 1'b1;
        read_address <= addr;
        @(posedge axi_ACLK);
        read_start   <= 1'b0;
        @(negedge axi_ACLK);
        while (!read_done) @(negedge axi_ACLK);
        exp_data = '0;                           // refused reads return zero.
        exp_resp = axi_pkg::SLVERR;
        if (addr < `MEM_WORDS * 4) begin
            idx      = addr[IDX_W+1:2];
            exp_data = ref_mem[idx];
            exp_resp = axi_pkg::OKAY;
        end
        check_data("read_data_o", read_data, exp_data);
        check_resp("read_response_o", read_response, exp_resp);
        reads_issued++;
    endtask

    task automatic random_op(input logic allow_error);
        logic [31:0] r;
        logic        bad;
        r   = $random(seed);
        bad = allow_error && (r[15:8] % 8'd5 == 8'd0);   // about one in five.
        if (r[0]) begin
            issue_write(random_address(bad), $random(seed), r[7:4]);
        end else begin
            issue_read(random_address(bad));
        end
    endtask

    task automatic finish_test(input string name);
        repeat (3) @(negedge axi_ACLK);          // late or doubled done pulses land here.
        check_count("write", write_done_cnt, writes_issued);
        check_count("read", read_done_cnt, reads_issued);
        if (test_errs == 0) begin
            pass_cnt++;
            $display("test %s: passed", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // background processes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin : grant_driver
        write_grant <= 1'b1;
        read_grant  <= 1'b1;
        stall_cnt   = 0;
        grant_seed  = 42;
        forever begin
            @(posedge axi_ACLK);
            grant_rnd = $random(grant_seed);
            if (stall_cnt != 0) begin
                stall_cnt = stall_cnt - 1;
                if (stall_cnt == 0) begin
                    write_grant <= 1'b1;         // router settled again.
                    read_grant  <= 1'b1;
                end
            end else if (stall_en && grant_rnd[2:0] == 3'd0) begin
                stall_cnt   = int'(grant_rnd[7:4]) % 9;   // 0 to 8 cycles.
                write_grant <= (stall_cnt == 0) | grant_rnd[8];
                read_grant  <= (stall_cnt == 0) | grant_rnd[9];
            end
        end
    end : grant_driver

    initial begin : done_counter
        write_done_cnt = 0;
        read_done_cnt  = 0;
        forever begin
            @(negedge axi_ACLK);
            if (write_done) write_done_cnt++;
            if (read_done) read_done_cnt++;
        end
    end : done_counter

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge axi_ACLK);
            cycle_cnt++;
        end
        $display("run stopped after %0d cycles without finishing", cycle_cnt);
        $display("TEST RESULT: FAIL");
        $finish;
    end : watchdog

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin : stimulus
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        seed          = 42;
        stall_en      = 1'b0;
        test_errs     = 0;
        pass_cnt      = 0;
        fail_cnt      = 0;
        writes_issued = 0;
        reads_issued  = 0;
        write_start   <= 1'b0;
        write_address <= '0;
        write_data    <= '0;
        write_strobe  <= '0;
        read_start    <= 1'b0;
        read_address  <= '0;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            ref_mem[i] = '0;                     // slave memory clears at reset.
        end
        @(posedge axi_ARESETN);

        repeat (5) begin
            @(negedge axi_ACLK);
            check_bit("write_done_o", write_done, 1'b0);
            check_bit("read_done_o", read_done, 1'b0);
        end
        finish_test("reset state");

        for (int i = 0; i < PAIR_OPS / 2; i++) begin
            addr = random_address(1'b0);
            data = $random(seed);
            issue_write(addr, data, 4'hF);
            issue_read(addr);
        end
        finish_test("write then read back");

        for (int i = 0; i < PAIR_OPS / 2; i++) begin
            addr = random_address(1'b0);
            data = $random(seed);
            strb = data[3:0] ^ data[7:4];
            if (strb == 4'hF) strb = 4'h5;       // keep it partial.
            issue_write(addr, data, strb);
            issue_read(addr);
        end
        finish_test("byte strobes");

        issue_write(random_address(1'b1), $random(seed), 4'hF);
        issue_read(random_address(1'b1));
        for (int i = 0; i < `MEM_WORDS; i++) begin
            issue_read(i * 4);                   // whole memory sweep.
        end
        finish_test("out of range access");

        stall_en = 1'b1;
        for (int i = 0; i < STALL_OPS; i++) begin
            random_op(1'b0);
        end
        finish_test("grant stalls");

        for (int i = 0; i < RANDOM_OPS; i++) begin
            random_op(1'b1);
        end
        stall_en = 1'b0;
        finish_test("random sequence");

        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end : stimulus

endmodule

`default_nettype wire

// File: axi_subsystem.f
+incdir+common
common/axi_pkg.sv
axi_master/axi_master.sv
verilog/axi_reg_slice.sv
axi_slave/axi_mem_slave.sv
verilog/axi_subsystem.sv
verification/tb_clock_gen.sv
verification/tb_axi_subsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile with verilator, run, then decide on the log contents
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_axi_subsystem -f axi_subsystem.f \
    && ./obj_dir/Vtb_axi_subsystem 2>&1 | tee sim.log \
    || { echo "build or simulation did not complete"; exit 1; }
grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "simulation passed"
